// File: src/flappy_vga_pkg.sv
`default_nettype none

package flappy_vga_pkg;

   // screen coordinate wide enough for the full 800x521 raster
   typedef logic [10:0] coord_t;

   // ------------------------------
   // raster timing
   // ------------------------------

   // horizontal in pixel clocks
   localparam coord_t H_TOTAL = 11'd800;
   localparam coord_t H_PULSE = 11'd96;
   localparam coord_t H_BP    = 11'd144;
   localparam coord_t H_FP    = 11'd784;

   // vertical in lines
   localparam coord_t V_TOTAL = 11'd521;
   localparam coord_t V_PULSE = 11'd2;
   localparam coord_t V_BP    = 11'd31;
   localparam coord_t V_FP    = 11'd511;

   // ------------------------------
   // scene geometry
   // ------------------------------

   // an object spans its centre -/+ the half size
   localparam coord_t PIPE_HALF_W = 11'd25;
   localparam coord_t GAP_HALF_H  = 11'd50;

   // bird column is fixed in scene coordinates
   localparam coord_t BIRD_X      = 11'd100;
   localparam coord_t BIRD_HALF_W = 11'd9;
   localparam coord_t BIRD_HALF_H = 11'd6;

   localparam int N_PIPES = 2;

   // counter value to colour pin through the mask stage and colour register
   localparam int PIPE_LAT = 2;

   // ------------------------------
   // colours in 3/3/2 bits
   // ------------------------------

   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [1:0] b;
   } rgb_t;

   localparam rgb_t C_BLACK  = '{r: 3'b000, g: 3'b000, b: 2'b00};
   localparam rgb_t C_BORDER = '{r: 3'b111, g: 3'b000, b: 2'b00};
   localparam rgb_t C_BIRD   = '{r: 3'b111, g: 3'b111, b: 2'b00};
   localparam rgb_t C_PIPE   = '{r: 3'b000, g: 3'b111, b: 2'b00};
   // sky is magenta on this palette
   localparam rgb_t C_SKY    = '{r: 3'b111, g: 3'b000, b: 2'b11};

endpackage

`default_nettype wire

// File: src/raster_timing.sv
`default_nettype none

module raster_timing import flappy_vga_pkg::*; (
   input  logic   dclk,
   input  logic   clr,
   output coord_t hc,
   output coord_t vc,
   output logic   frame_start
);

   logic h_last;
   logic v_last;

   assign h_last = (hc == H_TOTAL - 11'd1);
   assign v_last = (vc == V_TOTAL - 11'd1);

   // ------------------------------
   // pixel and line counters
   // ------------------------------

   // parked on the last pixel of the frame during reset, so the
   // first edge after release wraps both counters to zero
   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         hc <= H_TOTAL - 11'd1;
         vc <= V_TOTAL - 11'd1;
      end else if (h_last) begin
         hc <= '0;
         if (v_last) begin
            vc <= '0;
         end else begin
            vc <= vc + 11'd1;
         end
      end else begin
         hc <= hc + 11'd1;
      end
   end

   // ------------------------------
   // frame strobe
   // ------------------------------

   // decoded one pixel ahead so the pulse lands with (0,0)
   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         frame_start <= 1'b0;
      end else begin
         frame_start <= h_last && v_last;
      end
   end

endmodule

`default_nettype wire

// File: src/pipe_mask.sv
`default_nettype none

module pipe_mask import flappy_vga_pkg::*; (
   input  logic   dclk,
   input  logic   clr,
   input  coord_t hc,
   input  coord_t vc,
   input  logic   frame_start,
   input  coord_t pipe_x,
   input  coord_t pipe_y,
   output logic   hit
);

   // bounds in counter units, lower inclusive, upper exclusive
   coord_t x_lo;
   coord_t x_hi;
   coord_t gap_lo;
   coord_t gap_hi;

   logic in_cols;
   logic in_gap;

   // positions are sampled once per frame so the picture never tears
   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         x_lo   <= '0;
         x_hi   <= '0;
         gap_lo <= '0;
         gap_hi <= '0;
      end else if (frame_start) begin
         x_lo   <= pipe_x - PIPE_HALF_W + H_BP;
         x_hi   <= pipe_x + PIPE_HALF_W + H_BP;
         gap_lo <= pipe_y - GAP_HALF_H + V_BP;
         gap_hi <= pipe_y + GAP_HALF_H + V_BP;
      end
   end

   assign in_cols = (hc >= x_lo) && (hc < x_hi);
   assign in_gap  = (vc >= gap_lo) && (vc < gap_hi);

   // pipe body is everything in its columns except the gap
   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         hit <= 1'b0;
      end else begin
         hit <= in_cols && !in_gap;
      end
   end

endmodule

`default_nettype wire

// File: src/bird_mask.sv
`default_nettype none

module bird_mask import flappy_vga_pkg::*; (
   input  logic   dclk,
   input  logic   clr,
   input  coord_t hc,
   input  coord_t vc,
   input  logic   frame_start,
   input  coord_t bird_y,
   output logic   hit
);

   coord_t y_lo;
   coord_t y_hi;

   logic in_cols;
   logic in_rows;

   // only the row moves, the column span is fixed by BIRD_X
   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         y_lo <= '0;
         y_hi <= '0;
      end else if (frame_start) begin
         y_lo <= bird_y - BIRD_HALF_H + V_BP;
         y_hi <= bird_y + BIRD_HALF_H + V_BP;
      end
   end

   assign in_cols = (hc >= BIRD_X - BIRD_HALF_W + H_BP) &&
                    (hc <  BIRD_X + BIRD_HALF_W + H_BP);
   assign in_rows = (vc >= y_lo) && (vc < y_hi);

   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         hit <= 1'b0;
      end else begin
         hit <= in_cols && in_rows;
      end
   end

endmodule

`default_nettype wire

// File: src/pixel_compositor.sv
`default_nettype none

module pixel_compositor import flappy_vga_pkg::*; (
   input  logic               dclk,
   input  logic               clr,
   input  coord_t             hc,
   input  coord_t             vc,
   input  logic               bird_hit,
   input  logic [N_PIPES-1:0] pipe_hit,
   output logic               hsync,
   output logic               vsync,
   output logic [2:0]         red,
   output logic [2:0]         green,
   output logic [1:0]         blue
);

   coord_t hc_d;
   coord_t vc_d;

   logic active;
   logic on_border;
   logic any_pipe;
   rgb_t pix;

   // ------------------------------
   // counter alignment
   // ------------------------------

   // one stage to line up with the registered mask hits;
   // reset value matches the timing counters so syncs stay idle
   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         hc_d <= H_TOTAL - 11'd1;
         vc_d <= V_TOTAL - 11'd1;
      end else begin
         hc_d <= hc;
         vc_d <= vc;
      end
   end

   // ------------------------------
   // colour priority
   // ------------------------------

   assign active    = (hc_d >= H_BP) && (hc_d < H_FP) && (vc_d >= V_BP) && (vc_d < V_FP);
   assign on_border = (hc_d == H_BP) || (hc_d == H_FP - 11'd1) ||
                      (vc_d == V_BP) || (vc_d == V_FP - 11'd1);
   assign any_pipe  = |pipe_hit;

   // bird is drawn over the pipes, the border over everything
   always_comb begin
      if (!active) begin
         pix = C_BLACK;
      end else if (on_border) begin
         pix = C_BORDER;
      end else if (bird_hit) begin
         pix = C_BIRD;
      end else if (any_pipe) begin
         pix = C_PIPE;
      end else begin
         pix = C_SKY;
      end
   end

   // colour and syncs leave through the same register stage
   always_ff @(posedge dclk or posedge clr) begin
      if (clr) begin
         hsync <= 1'b1;
         vsync <= 1'b1;
         red   <= '0;
         green <= '0;
         blue  <= '0;
      end else begin
         // active low pulses at the start of each line and frame
         hsync <= (hc_d >= H_PULSE);
         vsync <= (vc_d >= V_PULSE);
         red   <= pix.r;
         green <= pix.g;
         blue  <= pix.b;
      end
   end

endmodule

`default_nettype wire

// File: src/flappy_vga_top.sv
`default_nettype none

module flappy_vga_top import flappy_vga_pkg::*; (
   input  logic       dclk,
   input  logic       clr,
   input  coord_t     bird_y,
   input  coord_t     pipe_x [N_PIPES],
   input  coord_t     pipe_y [N_PIPES],
   output logic       hsync,
   output logic       vsync,
   output logic [2:0] red,
   output logic [2:0] green,
   output logic [1:0] blue
);

   coord_t hc;
   coord_t vc;
   logic   frame_start;

   logic               bird_hit;
   logic [N_PIPES-1:0] pipe_hit;

   raster_timing timing_i (
      .dclk        (dclk),
      .clr         (clr),
      .hc          (hc),
      .vc          (vc),
      .frame_start (frame_start)
   );

   // ------------------------------
   // object masks
   // ------------------------------

   for (genvar i = 0; i < N_PIPES; i++) begin : g_pipe
      pipe_mask pipe_i (
         .dclk        (dclk),
         .clr         (clr),
         .hc          (hc),
         .vc          (vc),
         .frame_start (frame_start),
         .pipe_x      (pipe_x[i]),
         .pipe_y      (pipe_y[i]),
         .hit         (pipe_hit[i])
      );
   end

   bird_mask bird_i (
      .dclk        (dclk),
      .clr         (clr),
      .hc          (hc),
      .vc          (vc),
      .frame_start (frame_start),
      .bird_y      (bird_y),
      .hit         (bird_hit)
   );

   pixel_compositor comp_i (
      .dclk     (dclk),
      .clr      (clr),
      .hc       (hc),
      .vc       (vc),
      .bird_hit (bird_hit),
      .pipe_hit (pipe_hit),
      .hsync    (hsync),
      .vsync    (vsync),
      .red      (red),
      .green    (green),
      .blue     (blue)
   );

endmodule

`default_nettype wire

// File: verif/flappy_vga_properties.sv
`default_nettype none

module flappy_vga_properties import flappy_vga_pkg::*; (
   input logic       dclk,
   input logic       clr,
   input coord_t     hc,
   input coord_t     vc,
   input logic       frame_start,
   input logic       hsync,
   input logic       vsync,
   input logic [2:0] red,
   input logic [2:0] green,
   input logic [1:0] blue
);

   timeunit 1ns;
   timeprecision 1ps;

   // ------------------------------
   // raster counters
   // ------------------------------

   hc_in_range: assert property (@(posedge dclk) disable iff (clr) hc < H_TOTAL)
      else $error("pixel counter went past the end of the line");

   // strobe only at the frame origin
   frame_start_at_origin: assert property (@(posedge dclk) disable iff (clr)
      frame_start |-> (hc == '0 && vc == '0))
      else $error("frame strobe away from counter origin");

   // ------------------------------
   // outputs in reset
   // ------------------------------

   // sampled between rising edges once the reset has reached the registers
   idle_in_reset: assert property (@(negedge dclk)
      clr |-> (hsync && vsync && red == '0 && green == '0 && blue == '0))
      else $error("syncs or colour active while in reset");

endmodule

bind flappy_vga_top flappy_vga_properties props_i (.*);

`default_nettype wire

// File: verif/flappy_vga_tb.sv
`default_nettype none

module flappy_vga_tb;

   timeunit 1ns;
   timeprecision 1ps;

   // raster and scene constants
   localparam int H_TOT  = 800;
   localparam int V_TOT  = 521;
   localparam int FRAME  = H_TOT * V_TOT;
   localparam int H_SYNC = 96;
   localparam int V_SYNC = 2;
   localparam int H_ACT0 = 144;
   localparam int H_ACT1 = 784;
   localparam int V_ACT0 = 31;
   localparam int V_ACT1 = 511;
   localparam int PIPE_W2  = 25;
   localparam int GAP_H2   = 50;
   localparam int BIRD_COL = 100;
   localparam int BIRD_W2  = 9;
   localparam int BIRD_H2  = 6;
   localparam int NP  = 2;
   localparam int LAT = 2;
   localparam int GOLD_WORDS = 142;
   // counter line of a frame where the next frame's positions go in
   localparam int SWAP_LINE = 240;
   localparam logic [7:0] BLACK  = 8'h00;
   localparam logic [7:0] BORDER = 8'he0;
   localparam logic [7:0] BIRD   = 8'hfc;
   localparam logic [7:0] PIPE   = 8'h1c;
   localparam logic [7:0] SKY    = 8'he3;

   logic        dclk = 1'b0;
   logic        clr;
   logic [10:0] bird_y;
   logic [10:0] pipe_x [NP];
   logic [10:0] pipe_y [NP];
   logic        hsync;
   logic        vsync;
   logic [2:0]  red;
   logic [2:0]  green;
   logic [1:0]  blue;

   logic [15:0] gold [GOLD_WORDS];
   int          m_bird [8];
   int          m_px [8][NP];
   int          m_py [8][NP];
   int          pr_f [$];
   int          pr_h [$];
   int          pr_v [$];
   logic [7:0]  pr_c [$];
   int          n_frames;
   int          run_pixels;
   int          timeout_lim;
   int          probe_ptr;
   int          edges;
   int          cycles;
   int          hlow;
   int          vlow;
   int          checks [6];
   int          errs [6];
   string       names [6] = '{"reset", "sync timing", "blank/border", "pipes/sky",
                              "bird priority", "frame latch"};
   logic [31:0] rng = 32'he953_4c3a;

   flappy_vga_top dut_i (
      .dclk   (dclk),
      .clr    (clr),
      .bird_y (bird_y),
      .pipe_x (pipe_x),
      .pipe_y (pipe_y),
      .hsync  (hsync),
      .vsync  (vsync),
      .red    (red),
      .green  (green),
      .blue   (blue)
   );

   always #4 dclk = ~dclk;

   // edges since reset release and the run limit
   always @(posedge dclk) begin
      cycles <= cycles + 1;
      edges  <= clr ? 0 : edges + 1;
      if (cycles >= timeout_lim) begin
         $display("timeout, the run did not end within %0d cycles", timeout_lim);
         $display("Simulation failed");
         $finish;
      end
   end

   // ------------------------------
   // reference model and helpers
   // ------------------------------

   function automatic logic [7:0] ref_colour(int f, int h, int v);
      if (h < H_ACT0 || h >= H_ACT1 || v < V_ACT0 || v >= V_ACT1) return BLACK;
      if (h == H_ACT0 || h == H_ACT1 - 1 || v == V_ACT0 || v == V_ACT1 - 1) return BORDER;
      if (h >= BIRD_COL - BIRD_W2 + H_ACT0 && h < BIRD_COL + BIRD_W2 + H_ACT0 &&
          v >= m_bird[f] - BIRD_H2 + V_ACT0 && v < m_bird[f] + BIRD_H2 + V_ACT0) return BIRD;
      for (int i = 0; i < NP; i++) begin
         if (h >= m_px[f][i] - PIPE_W2 + H_ACT0 && h < m_px[f][i] + PIPE_W2 + H_ACT0 &&
             !(v >= m_py[f][i] - GAP_H2 + V_ACT0 && v < m_py[f][i] + GAP_H2 + V_ACT0))
            return PIPE;
      end
      return SKY;
   endfunction

   function automatic logic [31:0] xorshift(logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_val(int t, string name, logic [31:0] exp, logic [31:0] got);
      checks[t]++;
      assert (got === exp) else begin
         errs[t]++;
         $display("Fail at %0d ns: %s expected 'h%0h, got 'h%0h", $time, name, exp, got);
      end
   endtask

   task automatic report_test(int t);
      if (errs[t] == 0)
         $display("test %-14s ok, %0d checks", names[t], checks[t]);
      else
         $display("test %-14s FAILED, %0d of %0d checks wrong", names[t], errs[t], checks[t]);
   endtask

   task automatic wait_counter(int idx);
      while (edges - 1 < idx) @(negedge dclk);
      @(posedge dclk);
   endtask

   task automatic drive_positions(int f);
      bird_y <= m_bird[f];
      for (int i = 0; i < NP; i++) begin
         pipe_x[i] <= m_px[f][i];
         pipe_y[i] <= m_py[f][i];
      end
   endtask

   // ------------------------------
   // output checker
   // ------------------------------

   // outputs are sampled on the falling edge
   always @(negedge dclk) begin
      int         idx;
      int         f;
      int         h;
      int         v;
      int         t;
      int         ft;
      logic [7:0] rgb;
      logic [7:0] exp;
      idx = edges - 1 - LAT;
      rgb = {red, green, blue};
      if (clr || idx < 0) begin
         check_val(0, "hsync", 1, hsync);
         check_val(0, "vsync", 1, vsync);
         check_val(0, "red/green/blue", BLACK, rgb);
      end else if (idx < run_pixels) begin
         f   = idx / FRAME;
         h   = idx % H_TOT;
         v   = (idx % FRAME) / H_TOT;
         t   = (idx < H_TOT) ? 0 : 1;
         ft  = (idx < H_TOT) ? 0 : ((f + 2 > 5) ? 5 : f + 2);
         exp = ref_colour(f, h, v);
         check_val(t, "hsync", h >= H_SYNC, hsync);
         check_val(t, "vsync", v >= V_SYNC, vsync);
         check_val(ft, "red/green/blue", exp, rgb);
         // pulse widths are checked as each pulse ends
         if (!hsync) begin
            hlow++;
         end else if (hlow != 0) begin
            check_val(t, "hsync low width", H_SYNC, hlow);
            hlow = 0;
         end
         if (!vsync) begin
            vlow++;
         end else if (vlow != 0) begin
            check_val(t, "vsync low width", V_SYNC * H_TOT, vlow);
            vlow = 0;
         end
         if (probe_ptr < pr_f.size() && pr_f[probe_ptr] == f &&
             pr_h[probe_ptr] == h && pr_v[probe_ptr] == v) begin
            check_val(ft, $sformatf("golden rgb (%0d,%0d)", h, v), exp, pr_c[probe_ptr]);
            check_val(ft, $sformatf("red/green/blue (%0d,%0d)", h, v), pr_c[probe_ptr], rgb);
            probe_ptr++;
         end
         if (idx == H_TOT - 1)
            report_test(0);
         if (h == H_TOT - 1 && v == V_TOT - 1 && (ft < 5 || f == n_frames))
            report_test(ft);
      end
   end

   // ------------------------------
   // stimulus
   // ------------------------------

   initial begin
      int p;
      int np;
      int total;
      int n_checks;
      clr    = 1'b1;
      bird_y = '0;
      pipe_x = '{default: '0};
      pipe_y = '{default: '0};
      timeout_lim = 2 * FRAME;
      $readmemh("verif/flappy_vga_golden.txt", gold);
      n_frames = gold[0];
      if (n_frames < 1 || n_frames > 7) begin
         $display("golden file is missing or holds no frames");
         $display("Simulation failed");
         $finish;
      end
      p = 1;
      for (int f = 0; f < n_frames; f++) begin
         np        = gold[p];
         m_bird[f] = gold[p + 1];
         for (int i = 0; i < NP; i++) begin
            m_px[f][i] = gold[p + 2 + 2 * i];
            m_py[f][i] = gold[p + 3 + 2 * i];
         end
         p += 2 + 2 * NP;
         for (int k = 0; k < np; k++) begin
            pr_f.push_back(f);
            pr_h.push_back(gold[p]);
            pr_v.push_back(gold[p + 1]);
            pr_c.push_back(gold[p + 2][7:0]);
            p += 3;
         end
      end
      // one extra frame shows the randomized positions
      run_pixels  = (n_frames + 1) * FRAME;
      timeout_lim = (n_frames + 2) * FRAME;
      repeat (4) @(posedge dclk);
      clr <= 1'b0;
      drive_positions(0);

      // every frame's positions arrive part way through the frame before
      for (int f = 1; f <= n_frames; f++) begin
         if (f == n_frames) begin
            rng       = xorshift(rng);
            m_bird[f] = 20 + rng % 440;
            for (int i = 0; i < NP; i++) begin
               rng        = xorshift(rng);
               m_px[f][i] = 30 + rng % 580;
               rng        = xorshift(rng);
               m_py[f][i] = 60 + rng % 360;
            end
         end
         wait_counter((f - 1) * FRAME + SWAP_LINE * H_TOT);
         drive_positions(f);
      end

      while (edges - 1 - LAT < run_pixels) @(negedge dclk);
      report_test(1);
      if (probe_ptr != pr_f.size()) begin
         errs[5]++;
         $display("only %0d of %0d golden probes were reached", probe_ptr, pr_f.size());
      end
      total    = 0;
      n_checks = 0;
      foreach (errs[i]) begin
         total    += errs[i];
         n_checks += checks[i];
      end
      $display("6 tests, %0d checks, %0d errors", n_checks, total);
      if (total == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/flappy_vga_golden.txt
// frame line: probe count, bird_y, pipe_x0, pipe_y0, pipe_x1, pipe_y1 (scene units)
// probe line: hc, vc (counter units), expected rgb 3/3/2; all values hex
4
// frame 0, blanking and border
9 C8 96 F0 1C2 96
0 0 00
12C A 00
90 1F E0
190 1F E0
90 C8 E0
30F 12C E0
316 12C 00
1F4 1FE E0
1F4 203 00
// frame 1, pipes and sky
C 190 C8 96 1F4 12C
154 64 1C
154 B4 E3
280 C8 1C
154 E6 E3
154 E7 1C
13E FA E3
13F FA 1C
170 FA 1C
171 FA E3
280 14A E3
2BC 14A E3
280 1C2 1C
// frame 2, bird over pipe
A 64 64 12C 190 C8
F0 78 1C
EB 7D FC
EA 82 1C
F3 82 FC
FD 82 1C
FC 88 FC
F3 89 1C
21C C8 E3
F3 12C E3
21C 12C 1C
// frame 3, positions change mid frame
8 FA 12C FA 226 15E
1B8 64 1C
1B8 FA E3
F0 118 FC
2BC 12C 1C
2BC 17C E3
1B8 190 1C
258 1C2 E3
2BC 1D6 1C

// File: sim.f
src/flappy_vga_pkg.sv
src/raster_timing.sv
src/pipe_mask.sv
src/bird_mask.sv
src/pixel_compositor.sv
src/flappy_vga_top.sv
verif/flappy_vga_properties.sv
verif/flappy_vga_tb.sv

// File: Bender.yml
package:
  name: flappy_vga

sources:
  # design
  - files:
      - src/flappy_vga_pkg.sv
      - src/raster_timing.sv
      - src/pipe_mask.sv
      - src/bird_mask.sv
      - src/pixel_compositor.sv
      - src/flappy_vga_top.sv

  # verification
  - target: test
    files:
      - verif/flappy_vga_properties.sv
      - verif/flappy_vga_tb.sv
